/* Makefile */
# Verilator build and run for the OSD overlay testbench

VERILATOR ?= verilator
TOP       ?= tbOsdOverlay
RTL_TOP   ?= osdOverlay
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(filter hdl/%,$(shell cat $(FILELIST)))

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
hdl/osdPkg.sv
hdl/osdSpiReceiver.sv
hdl/osdCharBuffer.sv
hdl/syncAnalyzer.sv
hdl/osdWindow.sv
hdl/osdMixer.sv
hdl/osdOverlay.sv
sim/tbOsdOverlay.sv

/* hdl/osdCharBuffer.sv */
// ****************************************
// OSD display buffer
// ****************************************
`timescale 1ns/1ns

module osdCharBuffer (
	input  logic                          SPI_SCK,
	input  osdPkg::bufWrite_t             bufWr,
	input  logic                          clk_sys,
	input  logic [osdPkg::BUF_ADDR_W-1:0] rdAddr,
	output logic [7:0]                    rdData
);

	logic [7:0] mem [0:(1 << osdPkg::BUF_ADDR_W)-1];

	// write port in the serial clock domain
	always_ff @(posedge SPI_SCK) begin
		if (bufWr.we)
			mem[bufWr.addr] <= bufWr.data;
	end

	// registered read on the pixel clock
	always_ff @(posedge clk_sys) begin
		rdData <= mem[rdAddr];
	end

endmodule

/* hdl/osdMixer.sv */
// ****************************************
// OSD colour mixer
// ****************************************
`timescale 1ns/1ns

module osdMixer #(
	parameter logic [osdPkg::COLOR_W-1:0] osdColor = 6'h3c
) (
	input  logic              clk_sys,
	input  osdPkg::videoSig_t videoIn,
	input  logic              inWindow,
	input  logic              osdPixel,
	input  logic              osdEnable,
	output osdPkg::videoSig_t videoOut,
	output logic              osdShown
);

	logic              enMeta   = 1'b0;
	logic              enSync   = 1'b0;
	logic              shownReg = 1'b0;
	logic              active;
	osdPkg::rgbPixel_t osdRgb;

	// enable comes from the serial clock domain
	always_ff @(posedge clk_sys) begin
		enMeta   <= osdEnable;
		enSync   <= enMeta;
		shownReg <= enSync;
	end

	assign active = enSync && inWindow;

	// pixel bit on top, OSD tint in the middle, dimmed input below
	assign osdRgb.r = {{2{osdPixel}}, osdColor[5:4], videoIn.rgb.r[5:4]};
	assign osdRgb.g = {{2{osdPixel}}, osdColor[3:2], videoIn.rgb.g[5:4]};
	assign osdRgb.b = {{2{osdPixel}}, osdColor[1:0], videoIn.rgb.b[5:4]};

	always_ff @(posedge clk_sys) begin
		videoOut.rgb   <= active ? osdRgb : videoIn.rgb;
		videoOut.hSync <= videoIn.hSync;
		videoOut.vSync <= videoIn.vSync;
	end

	assign osdShown = shownReg;

	// with the shown flag low the output is the plain delayed input
	assert property (@(posedge clk_sys)
			!osdShown |-> (videoOut.rgb == $past(videoIn.rgb)))
		else $error("OSD overlay visible while osdShown is low");

endmodule

/* hdl/osdOverlay.sv */
// ****************************************
// On-screen display overlay
// ****************************************
`timescale 1ns/1ns

module osdOverlay #(
	parameter logic [osdPkg::COUNT_W-1:0] osdXOffset = '0,
	parameter logic [osdPkg::COUNT_W-1:0] osdYOffset = '0,
	parameter logic [osdPkg::COLOR_W-1:0] osdColor   = 6'h3c
) (
	input  logic              clk_sys,
	input  logic              SPI_SCK,
	input  logic              SPI_SS3,
	input  logic              SPI_DI,
	input  osdPkg::videoSig_t videoIn,
	output osdPkg::videoSig_t videoOut,
	output logic              osdShown
);

	osdPkg::bufWrite_t             bufWr;
	logic                          osdEnable;
	osdPkg::beamPos_t              beam;
	osdPkg::screenGeom_t           geom;
	logic [osdPkg::BUF_ADDR_W-1:0] rdAddr;
	logic [7:0]                    rdData;
	logic                          inWindow;
	logic                          osdPixel;

	osdSpiReceiver i_osdSpiReceiver (
		.SPI_SCK   (SPI_SCK),
		.SPI_SS3   (SPI_SS3),
		.SPI_DI    (SPI_DI),
		.bufWr     (bufWr),
		.osdEnable (osdEnable)
	);

	osdCharBuffer i_osdCharBuffer (
		.SPI_SCK (SPI_SCK),
		.bufWr   (bufWr),
		.clk_sys (clk_sys),
		.rdAddr  (rdAddr),
		.rdData  (rdData)
	);

	syncAnalyzer i_syncAnalyzer (
		.clk_sys (clk_sys),
		.videoIn (videoIn),
		.beam    (beam),
		.geom    (geom)
	);

	osdWindow #(
		.osdXOffset (osdXOffset),
		.osdYOffset (osdYOffset)
	) i_osdWindow (
		.clk_sys  (clk_sys),
		.beam     (beam),
		.geom     (geom),
		.videoIn  (videoIn),
		.rdAddr   (rdAddr),
		.rdData   (rdData),
		.inWindow (inWindow),
		.osdPixel (osdPixel)
	);

	osdMixer #(
		.osdColor (osdColor)
	) i_osdMixer (
		.clk_sys   (clk_sys),
		.videoIn   (videoIn),
		.inWindow  (inWindow),
		.osdPixel  (osdPixel),
		.osdEnable (osdEnable),
		.videoOut  (videoOut),
		.osdShown  (osdShown)
	);

endmodule

/* hdl/osdPkg.sv */
// ****************************************
// OSD shared types and constants
// ****************************************

package osdPkg;

	localparam int COLOR_W          = 6;
	localparam int COUNT_W          = 10;
	localparam int BUF_ADDR_W       = 11;
	localparam int OSD_WIDTH        = 256;
	localparam int OSD_HEIGHT       = 128;
	localparam int DOUBLESCAN_LINES = 350;

	// opcode sits in the top five bits of the command byte
	typedef enum logic [4:0] {
		CMD_WRITE  = 5'b00100,
		CMD_ENABLE = 5'b01000
	} osdCmd_e;

	typedef struct packed {
		logic [COLOR_W-1:0] r;
		logic [COLOR_W-1:0] g;
		logic [COLOR_W-1:0] b;
	} rgbPixel_t;

	typedef struct packed {
		rgbPixel_t rgb;
		logic      hSync;
		logic      vSync;
	} videoSig_t;

	typedef struct packed {
		logic                  we;
		logic [BUF_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} bufWrite_t;

	typedef struct packed {
		logic [COUNT_W-1:0] hCnt;
		logic [COUNT_W-1:0] vCnt;
	} beamPos_t;

	typedef struct packed {
		logic [COUNT_W-1:0] width;
		logic [COUNT_W-1:0] height;
		logic               hsPol;
		logic               vsPol;
		logic               doublescan;
	} screenGeom_t;

endpackage

/* hdl/osdSpiReceiver.sv */
// ****************************************
// OSD serial command receiver
// ****************************************
`timescale 1ns/1ns

module osdSpiReceiver (
	input  logic              SPI_SCK,
	input  logic              SPI_SS3,
	input  logic              SPI_DI,
	output osdPkg::bufWrite_t bufWr,
	output logic              osdEnable
);

	localparam logic [4:0] ENABLE_OP = osdPkg::CMD_ENABLE;

	logic [3:0]                    bitCnt;
	logic [osdPkg::BUF_ADDR_W-1:0] wrAddr;
	logic [6:0]                    shiftReg;
	logic [7:0]                    rxByte;
	osdPkg::osdCmd_e               cmdOp;
	logic                          enableFlag = 1'b0;

	// byte as it completes on the current edge
	assign rxByte = {shiftReg, SPI_DI};

	// bits 0..7 are the command, then payload bytes at 8..15
	always_ff @(posedge SPI_SCK or posedge SPI_SS3) begin
		if (SPI_SS3) begin
			bitCnt <= '0;
			wrAddr <= '0;
		end else begin
			bitCnt <= (bitCnt == 4'd15) ? 4'd8 : bitCnt + 4'd1;
			if (bitCnt == 4'd7)
				wrAddr <= {rxByte[2:0], 8'h00};
			if (bufWr.we)
				wrAddr <= wrAddr + 1'b1;
		end
	end

	always_ff @(posedge SPI_SCK) begin
		shiftReg <= rxByte[6:0];
		if (bitCnt == 4'd7) begin
			cmdOp <= osdPkg::osdCmd_e'(rxByte[7:3]);
			// enable and disable share one opcode, bit 0 picks
			if (rxByte[7:4] == ENABLE_OP[4:1])
				enableFlag <= rxByte[0];
		end
	end

	assign bufWr.we   = (cmdOp == osdPkg::CMD_WRITE) && (bitCnt == 4'd15);
	assign bufWr.addr = wrAddr;
	assign bufWr.data = rxByte;
	assign osdEnable  = enableFlag;

	// a write run on page 7 must stop before the address wraps to page 0
	property noAddrWrap;
		@(posedge SPI_SCK) disable iff (SPI_SS3)
			(bufWr.we && (&bufWr.addr)) |=> (!bufWr.we) [*8];
	endproperty
	assert property (noAddrWrap)
		else $error("OSD write address wrapped past page 7");

endmodule

/* hdl/osdWindow.sv */
// ****************************************
// OSD window placement and fetch
// ****************************************
`timescale 1ns/1ns

module osdWindow #(
	parameter logic [osdPkg::COUNT_W-1:0] osdXOffset = '0,
	parameter logic [osdPkg::COUNT_W-1:0] osdYOffset = '0
) (
	input  logic                          clk_sys,
	input  osdPkg::beamPos_t              beam,
	input  osdPkg::screenGeom_t           geom,
	input  osdPkg::videoSig_t             videoIn,
	output logic [osdPkg::BUF_ADDR_W-1:0] rdAddr,
	input  logic [7:0]                    rdData,
	output logic                          inWindow,
	output logic                          osdPixel
);

	localparam int            CW    = osdPkg::COUNT_W;
	localparam logic [CW-1:0] WIN_W = CW'(osdPkg::OSD_WIDTH);
	localparam logic [CW-1:0] WIN_H = CW'(osdPkg::OSD_HEIGHT);

	logic [CW-1:0] winH;
	logic [CW-1:0] hStart;
	logic [CW-1:0] hEnd;
	logic [CW-1:0] vStart;
	logic [CW-1:0] vEnd;
	logic [CW-1:0] hNext;
	logic [CW-1:0] osdX;
	logic [CW-1:0] osdY;
	logic [CW-1:0] fetchX;
	logic [2:0]    page;
	logic [2:0]    bitSel;
	logic          syncOk;

	// double-scanned frames get twice the lines
	assign winH = geom.doublescan ? (WIN_H << 1) : WIN_H;

	always_ff @(posedge clk_sys) begin
		hStart <= ((geom.width - WIN_W) >> 1) + osdXOffset;
		hEnd   <= hStart + WIN_W;
		vStart <= ((geom.height - winH) >> 1) + osdYOffset;
		vEnd   <= vStart + winH;
	end

	assign hNext = beam.hCnt + 1'b1;
	assign osdX  = beam.hCnt - hStart;
	assign osdY  = beam.vCnt - vStart;

	// address and fetch take two cycles, so read two columns ahead
	assign fetchX = osdX + CW'(2);
	assign page   = geom.doublescan ? osdY[7:5] : osdY[6:4];
	assign bitSel = geom.doublescan ? osdY[4:2] : osdY[3:1];
	assign rdAddr = {page, fetchX[7:0]};

	assign syncOk = (videoIn.hSync != geom.hsPol) && (videoIn.vSync != geom.vsPol);

	always_ff @(posedge clk_sys) begin
		osdPixel <= rdData[bitSel];
		inWindow <= syncOk
			&& (hNext >= hStart) && (hNext < hEnd)
			&& (beam.vCnt >= vStart) && (beam.vCnt < vEnd);
	end

endmodule

/* hdl/syncAnalyzer.sv */
// ****************************************
// Video timing and sync polarity
// ****************************************
`timescale 1ns/1ns

module syncAnalyzer (
	input  logic                clk_sys,
	input  osdPkg::videoSig_t   videoIn,
	output osdPkg::beamPos_t    beam,
	output osdPkg::screenGeom_t geom
);

	localparam int CW = osdPkg::COUNT_W;

	logic          hsD;
	logic          hsD2;
	logic          vsD;
	logic          vsD2;
	logic          hsRise;
	logic          hsFall;
	logic          vsRise;
	logic          vsFall;
	logic [CW-1:0] hCnt;
	logic [CW-1:0] vCnt;
	logic [CW-1:0] hsHigh;
	logic [CW-1:0] hsLow;
	logic [CW-1:0] vsHigh;
	logic [CW-1:0] vsLow;

	always_ff @(posedge clk_sys) begin
		hsD  <= videoIn.hSync;
		hsD2 <= hsD;
		vsD  <= videoIn.vSync;
		vsD2 <= vsD;
	end

	assign hsRise = hsD && !hsD2;
	assign hsFall = !hsD && hsD2;
	assign vsRise = vsD && !vsD2;
	assign vsFall = !vsD && vsD2;

	// ****************************************
	// beam counters and period lengths
	// ****************************************

	always_ff @(posedge clk_sys) begin
		if (hsRise || hsFall)
			hCnt <= '0;
		else
			hCnt <= hCnt + 1'b1;
		if (hsFall)
			hsHigh <= hCnt + 1'b1;
		if (hsRise)
			hsLow <= hCnt + 1'b1;
	end

	// lines are counted on hsync rising edges
	always_ff @(posedge clk_sys) begin
		if (vsRise || vsFall)
			vCnt <= '0;
		else if (hsRise)
			vCnt <= vCnt + 1'b1;
		// every line of the phase has already bumped vCnt by its own hsync rise
		if (vsFall)
			vsHigh <= vCnt;
		if (vsRise)
			vsLow <= vCnt;
	end

	// shorter period is the sync pulse, the longer one the display
	always_ff @(posedge clk_sys) begin
		geom.hsPol      <= hsHigh < hsLow;
		geom.width      <= geom.hsPol ? hsLow : hsHigh;
		geom.vsPol      <= vsHigh < vsLow;
		geom.height     <= geom.vsPol ? vsLow : vsHigh;
		geom.doublescan <= geom.height > CW'(osdPkg::DOUBLESCAN_LINES);
	end

	assign beam.hCnt = hCnt;
	assign beam.vCnt = vCnt;

endmodule

/* sim/tbOsdOverlay.sv */
// ****************************************
// OSD overlay testbench
// ****************************************
`timescale 1ns/1ns

module tbOsdOverlay;

	localparam int H_TOTAL = 400;
	localparam int H_SYNC  = 40;
	localparam int V_SYNC  = 4;
	localparam int H_START = ((H_TOTAL - H_SYNC) - 256) / 2;
	localparam logic [5:0] OSD_COLOR = 6'h3c;

	logic              clk_sys = 1'b0;
	logic              SPI_SCK;
	logic              SPI_SS3;
	logic              SPI_DI;
	osdPkg::videoSig_t videoIn;
	osdPkg::videoSig_t videoOut;
	logic              osdShown;

	int                frameLines = 300;
	int                pixNo      = 0;
	int                lineNo     = 0;
	int                lastPix    = 0;
	int                lastLine   = 0;
	osdPkg::videoSig_t lastIn;
	int                errCount   = 0;
	int                checkCount = 0;
	int                testStart  = 0;
	logic [7:0]        shadow [0:511];
	logic [17:0]       rnd;

	always #4 clk_sys = ~clk_sys;

	osdOverlay i_osdOverlay (
		.clk_sys  (clk_sys),
		.SPI_SCK  (SPI_SCK),
		.SPI_SS3  (SPI_SS3),
		.SPI_DI   (SPI_DI),
		.videoIn  (videoIn),
		.videoOut (videoOut),
		.osdShown (osdShown)
	);

	// ****************************************
	// video generator, active-low syncs
	// ****************************************
	always @(negedge clk_sys) begin
		lastIn   = videoIn;
		lastPix  = pixNo;
		lastLine = lineNo;
		if (pixNo == H_TOTAL - 1) begin
			pixNo  = 0;
			lineNo = (lineNo >= frameLines - 1) ? 0 : lineNo + 1;
		end else begin
			pixNo = pixNo + 1;
		end
		rnd           = 18'($urandom);
		videoIn.rgb   = rnd;
		videoIn.hSync = (pixNo >= H_SYNC);
		videoIn.vSync = (lineNo >= V_SYNC);
	end

	function automatic logic [7:0] byteFor(input int addr);
		logic [10:0] a;
		a = 11'(addr);
		return (a[7:0] * 8'd29) ^ {5'b0, a[10:8]} ^ 8'h5a;
	endfunction

	// bit of the buffer shown at window point (x, y)
	function automatic logic pixelBit(input int x, input int y, input bit dbl);
		int         page;
		int         bitIdx;
		logic [7:0] b;
		page   = dbl ? y / 32 : y / 16;
		bitIdx = dbl ? (y / 4) % 8 : (y / 2) % 8;
		b      = shadow[page * 256 + x];
		return b[bitIdx];
	endfunction

	function automatic osdPkg::rgbPixel_t overlayRgb(input osdPkg::rgbPixel_t c, input logic p);
		osdPkg::rgbPixel_t o;
		o.r = {p, p, OSD_COLOR[5:4], c.r[5:4]};
		o.g = {p, p, OSD_COLOR[3:2], c.g[5:4]};
		o.b = {p, p, OSD_COLOR[1:0], c.b[5:4]};
		return o;
	endfunction

	task automatic sampleCycle();
		@(negedge clk_sys);
		#1;
	endtask

	task automatic spiBit(input logic b);
		@(negedge clk_sys) begin
			SPI_SCK = 1'b0;
			SPI_DI  = b;
		end
		@(negedge clk_sys);
		@(negedge clk_sys) SPI_SCK = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic spiByte(input logic [7:0] v);
		for (int i = 7; i >= 0; i--)
			spiBit(v[i]);
	endtask

	task automatic spiBegin();
		@(negedge clk_sys) SPI_SS3 = 1'b0;
	endtask

	task automatic spiEnd();
		@(negedge clk_sys) SPI_SCK = 1'b0;
		@(negedge clk_sys) SPI_SS3 = 1'b1;
	endtask

	task automatic sendEnable(input logic on);
		spiBegin();
		spiByte({7'b0100000, on});
		spiEnd();
	endtask

	task automatic writePage(input int page);
		logic [7:0] b;
		spiBegin();
		spiByte(8'h20 | page[7:0]);
		for (int a = 0; a < 256; a++) begin
			b = byteFor(page * 256 + a);
			shadow[page * 256 + a] = b;
			spiByte(b);
		end
		spiEnd();
	endtask

	task automatic waitShown(input logic level);
		int n;
		n = 0;
		while (osdShown !== level && n < 20) begin
			sampleCycle();
			n++;
		end
		if (osdShown !== level) begin
			$display("osdShown did not go to %0b within 20 clocks", level);
			errCount++;
		end
	endtask

	task automatic waitLine(input int line);
		int n;
		n = 0;
		sampleCycle();
		while (!(lastLine == line && lastPix == 0) && n < 500 * H_TOTAL) begin
			sampleCycle();
			n++;
		end
		if (n >= 500 * H_TOTAL) begin
			$display("line %0d never started on the video input", line);
			errCount++;
		end
	endtask

	task automatic waitFrames(input int count);
		for (int f = 0; f < count; f++)
			waitLine(0);
	endtask

	// window row y sits on line y + vStart + V_SYNC - 1
	function automatic int lineForRow(input int y, input bit dbl);
		int winH;
		winH = dbl ? 256 : 128;
		return y + ((frameLines - V_SYNC) - winH) / 2 + V_SYNC - 1;
	endfunction

	// ****************************************
	// one line of output against the model
	// ****************************************
	task automatic checkLine(input int line, input bit on, input bit dbl, inout int nOver,
		inout int nPass);
		int                x;
		int                y;
		int                winH;
		int                vStart;
		osdPkg::rgbPixel_t exp;
		bit                doCheck;
		winH   = dbl ? 256 : 128;
		// display height is the high vsync phase
		vStart = ((frameLines - V_SYNC) - winH) / 2;
		waitLine(line);
		for (int p = 0; p < H_TOTAL; p++) begin
			// sync edges reach the beam counters two clocks late
			x       = lastPix - H_SYNC - 2 - H_START;
			y       = lastLine - V_SYNC + 1 - vStart;
			doCheck = 1'b0;
			if (!on || x < -4 || x > 259 || y < -4 || y > winH + 3) begin
				exp     = lastIn.rgb;
				doCheck = 1'b1;
				nPass++;
			end else if (x >= 4 && x <= 251 && y >= 4 && y < (dbl ? 64 : 32)) begin
				exp     = overlayRgb(lastIn.rgb, pixelBit(x, y, dbl));
				doCheck = 1'b1;
				nOver++;
			end
			checkCount++;
			if (doCheck && videoOut.rgb !== exp) begin
				$display("ERR %0t: line %0d pixel %0d rgb %h expected %h", $time,
					lastLine, lastPix, videoOut.rgb, exp);
				errCount++;
			end
			if (videoOut.hSync !== lastIn.hSync || videoOut.vSync !== lastIn.vSync) begin
				$display("ERR %0t: line %0d pixel %0d syncs do not follow input", $time,
					lastLine, lastPix);
				errCount++;
			end
			if (!on && osdShown !== 1'b0) begin
				$display("ERR %0t: osdShown high while disabled", $time);
				errCount++;
			end
			if (p < H_TOTAL - 1)
				sampleCycle();
		end
	endtask

	task automatic reportTest(input string name);
		$display("test %s done, %0d errors", name, errCount - testStart);
		testStart = errCount;
	endtask

	task automatic testPassThrough();
		int nOver;
		int nPass;
		nOver = 0;
		nPass = 0;
		for (int l = 0; l < frameLines; l++)
			checkLine(l, 1'b0, 1'b0, nOver, nPass);
		reportTest("pass-through");
	endtask

	task automatic testEnableDisable();
		sendEnable(1'b1);
		waitShown(1'b1);
		sendEnable(1'b0);
		waitShown(1'b0);
		reportTest("enable/disable");
	endtask

	task automatic testOverlay(input bit dbl, input string name);
		int nOver;
		int nPass;
		int rows [4];
		nOver = 0;
		nPass = 0;
		if (dbl)
			rows = '{6, 30, 45, 60};
		else
			rows = '{5, 12, 20, 27};
		foreach (rows[i])
			checkLine(lineForRow(rows[i], dbl), 1'b1, dbl, nOver, nPass);
		if (nOver == 0) begin
			$display("no overlay pixels were checked in %s", name);
			errCount++;
		end
		reportTest(name);
	endtask

	task automatic testOutside();
		int nOver;
		int nPass;
		nOver = 0;
		nPass = 0;
		checkLine(lineForRow(-20, 1'b0), 1'b1, 1'b0, nOver, nPass);
		checkLine(lineForRow(20, 1'b0), 1'b1, 1'b0, nOver, nPass);
		checkLine(lineForRow(200, 1'b0), 1'b1, 1'b0, nOver, nPass);
		if (nPass == 0) begin
			$display("no pixels outside the window were checked");
			errCount++;
		end
		reportTest("outside window");
	endtask

	initial begin
		void'($urandom(97));
		SPI_SS3 = 1'b1;
		SPI_SCK = 1'b0;
		SPI_DI  = 1'b0;
		videoIn = '0;
		lastIn  = '0;
		repeat (3) @(negedge clk_sys);
		testPassThrough();
		testEnableDisable();
		writePage(0);
		writePage(1);
		sendEnable(1'b1);
		waitShown(1'b1);
		testOverlay(1'b0, "overlay content");
		testOutside();
		frameLines = 420;
		waitFrames(3);
		testOverlay(1'b1, "double scan");
		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
